//--- compile.f
hw/reord_pkg.sv
hw/ack_order_fifo.sv
hw/seg_done_tracker.sv
hw/seg_release.sv
hw/reord_top.sv
test/tb_clkgen.sv
test/reord_sva.sv
test/reord_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the release block testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module reord_tb \
    -f compile.f --Mdir obj_dir -o reord_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/reord_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test OK" sim.log; then
    exit 0
else
    exit 1
fi

//--- test/reord_tb.sv
/* Testbench for reord_top: order, back-pressure, full FIFO, errors, flush.
   A monitor keeps a reference queue of accepted ACKs and checks each release. */

`timescale 1ns/1ps

module reord_tb
    import reord_pkg::*;
;

    logic clk;
    logic rst;
    logic flush;
    logic ack_valid;
    ack_entry_t ack_entry;
    logic ack_ready;
    done_port_t done_0;
    done_port_t done_1;
    logic out_valid;
    ack_entry_t out_entry;
    logic out_ready;
    logic [4:0] pending;
    reord_err_t err;

    integer seed = 32'he59c_cb2c;
    ack_entry_t q[$];
    logic [NUM_SEQ-1:0] shadow = '0;
    int mon_errs = 0;
    int seq_errs = 0;
    int cycles = 0;
    logic flushing = 1'b0;
    logic rand_ready = 1'b0;
    int order[12];

    tb_clkgen u_clkgen (.clk(clk), .rst(rst));

    reord_top #(.FIFO_AW(4)) u_reord_top (
        .clk(clk), .rst(rst), .flush(flush),
        .ack_valid(ack_valid), .ack_entry(ack_entry), .ack_ready(ack_ready),
        .done_0(done_0), .done_1(done_1),
        .out_valid(out_valid), .out_entry(out_entry), .out_ready(out_ready),
        .pending(pending), .err(err)
    );

    task automatic mismatch(inout int cnt, input string name, input logic [63:0] exp,
                            input logic [63:0] act);
        cnt++;
        $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
    endtask

    task automatic send_ack(input int id);
        ack_entry_t e;
        e.info = INFO_W'({$random(seed), $random(seed)});
        e.seq  = seq_id_t'(id);
        @(posedge clk);
        ack_valid <= 1'b1;
        ack_entry <= e;
        do @(posedge clk); while (!ack_ready);
        ack_valid <= 1'b0;
    endtask

    // One cycle on each port, v0/v1 select which ports fire
    task automatic complete(input logic v0, input int id0, input logic v1, input int id1);
        @(posedge clk);
        done_0 <= '{valid: v0, seq: seq_id_t'(id0)};
        done_1 <= '{valid: v1, seq: seq_id_t'(id1)};
        @(posedge clk);
        done_0 <= '0;
        done_1 <= '0;
    endtask

    task automatic wait_size(input int n);
        while (q.size() != n) @(posedge clk);
    endtask

    ////////////////////
    // Reference monitor, sole owner of q and shadow

    always @(posedge clk)
    begin
        if (flushing)
        begin
            q.delete();
            shadow = '0;
        end
        else if (!rst)
        begin
            assert (int'(pending) == q.size())
                else mismatch(mon_errs, "pending", 64'(q.size()), 64'(pending));
            if (out_valid && out_ready)
            begin
                if (q.size() == 0)
                begin
                    mon_errs++;
                    $display("Output at %0t with no ACK waiting for it", $time);
                end
                else
                begin
                    assert (out_entry == q[0])
                        else mismatch(mon_errs, "out_entry", 64'(q[0]), 64'(out_entry));
                    if (!shadow[q[0].seq])
                    begin
                        mon_errs++;
                        $display("Id %0d released at %0t before completion", q[0].seq, $time);
                    end
                    shadow[q[0].seq] = 1'b0;
                    void'(q.pop_front());
                end
            end
            if (done_0.valid)
                shadow[done_0.seq] = 1'b1;
            if (done_1.valid)
                shadow[done_1.seq] = 1'b1;
            if (ack_valid && ack_ready)
                q.push_back(ack_entry);
        end
        if (rand_ready)
            out_ready <= 1'($random(seed));
    end

    // About 250 cycles of tests, limit leaves wide margin
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= 4000)
        begin
            $display("Timeout after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////
    // Stimulus

    initial
    begin
        int j;
        int t;
        flush = 1'b0;
        ack_valid = 1'b0;
        ack_entry = '0;
        done_0 = '0;
        done_1 = '0;
        out_ready = 1'b0;
        wait (!rst);
        while (!ack_ready) @(posedge clk);

        // Order under random back-pressure
        rand_ready = 1'b1;
        for (int i = 0; i < 12; i++)
        begin
            order[i] = (i + 3) % NUM_SEQ;
            send_ack(order[i]);
        end
        for (int i = 11; i > 0; i--)
        begin
            j = int'($unsigned($random(seed)) % (i + 1));
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 12; i++)
        begin
            j = $random(seed) & 1;
            complete(j == 0, order[i], j == 1, order[i]);
        end
        wait_size(0);
        rand_ready = 1'b0;

        // Full: one held, sixteen queued
        @(posedge clk);
        out_ready <= 1'b0;
        send_ack(0);
        complete(1'b1, 0, 1'b0, 0);
        while (!out_valid) @(posedge clk);
        for (int i = 0; i < NUM_SEQ; i++)
            send_ack(i);
        @(negedge clk);
        assert (!ack_ready) else mismatch(seq_errs, "ack_ready", 64'(0), 64'(ack_ready));
        assert (pending == 5'd17) else mismatch(seq_errs, "pending", 64'(17), 64'(pending));
        fork
            send_ack(0);
            begin
                repeat (4) @(posedge clk);
                out_ready <= 1'b1;
                for (int i = 0; i < NUM_SEQ; i++)
                    complete(i % 2 == 0, i, i % 2 == 1, i);
            end
        join
        wait_size(1);
        complete(1'b1, 0, 1'b0, 0);
        wait_size(0);

        // Same id on both ports
        send_ack(3);
        complete(1'b1, 3, 1'b1, 3);
        @(posedge clk);
        @(negedge clk);
        assert (err.dup_port) else mismatch(seq_errs, "err.dup_port", 64'(1), 64'(err.dup_port));
        repeat (6) @(posedge clk);
        wait_size(0);

        // Second completion of a still-marked id, per port
        complete(1'b1, 10, 1'b0, 0);
        repeat (2) @(posedge clk);
        complete(1'b1, 10, 1'b0, 0);
        @(posedge clk);
        @(negedge clk);
        assert (err.dup_mark_0)
            else mismatch(seq_errs, "err.dup_mark_0", 64'(1), 64'(err.dup_mark_0));
        complete(1'b0, 0, 1'b1, 9);
        repeat (2) @(posedge clk);
        complete(1'b0, 0, 1'b1, 9);
        @(posedge clk);
        @(negedge clk);
        assert (err.dup_mark_1)
            else mismatch(seq_errs, "err.dup_mark_1", 64'(1), 64'(err.dup_mark_1));

        // Flush with two ACKs waiting and bits 9, 10 left set
        send_ack(1);
        send_ack(2);
        flushing = 1'b1;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (4) @(posedge clk);
        flushing = 1'b0;
        @(negedge clk);
        assert (pending == '0) else mismatch(seq_errs, "pending", 64'(0), 64'(pending));
        send_ack(9);
        repeat (8)
        begin
            @(negedge clk);
            assert (!out_valid)
                else mismatch(seq_errs, "out_valid", 64'(0), 64'(out_valid));
        end
        complete(1'b0, 0, 1'b1, 9);
        wait_size(0);
        repeat (5) @(posedge clk);

        $display("Checks done: %0d monitor errors, %0d sequence errors", mon_errs, seq_errs);
        if (mon_errs + seq_errs == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- test/reord_sva.sv
/* Concurrent checks on the release block, bound into reord_top.
   Covers output stability, error causes and ACK blocking during flush. */

`timescale 1ns/1ps

module reord_sva
    import reord_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       flush_q,
    input done_port_t done_0,
    input done_port_t done_1,
    input logic       ack_ready,
    input logic       out_valid,
    input logic       out_ready,
    input ack_entry_t out_entry,
    input reord_err_t err
);

    // Stalled output keeps its payload
    a_out_stable: assert property (@(posedge clk) disable iff (rst || flush_q)
        out_valid && !out_ready |=> out_valid && $stable(out_entry))
        else $error("out_entry changed while stalled");

    // dup_port needs the same id on both ports two edges back
    a_dup_port: assert property (@(posedge clk) disable iff (rst)
        err.dup_port |-> $past(done_0.valid && done_1.valid && (done_0.seq == done_1.seq), 2))
        else $error("err.dup_port without matching ids on both ports");

    a_dup_mark_0: assert property (@(posedge clk) disable iff (rst)
        err.dup_mark_0 |-> $past(done_0.valid, 2))
        else $error("err.dup_mark_0 without a port 0 completion");

    a_dup_mark_1: assert property (@(posedge clk) disable iff (rst)
        err.dup_mark_1 |-> $past(done_1.valid, 2))
        else $error("err.dup_mark_1 without a port 1 completion");

    // No ACK taken while flushing
    a_flush_block: assert property (@(posedge clk) flush_q |-> !ack_ready)
        else $error("ack_ready high during flush");

endmodule

bind reord_top reord_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .flush_q   (flush_q),
    .done_0    (done_0),
    .done_1    (done_1),
    .ack_ready (ack_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_entry (out_entry),
    .err       (err)
);

//--- test/tb_clkgen.sv
/* Testbench clock and reset source, 20 ns period, reset for 10 cycles */

`timescale 1ns/1ps

module tb_clkgen
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- hw/reord_top.sv
/* Top of the in-order release block: ACK FIFO, completion tracker, release.
   Registers flush and reports pending entries and sequence errors. */

`timescale 1ns/1ps

module reord_top
    import reord_pkg::*;
#(
    parameter int FIFO_AW = 4
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,

    // ACK input
    input  logic             ack_valid,
    input  ack_entry_t       ack_entry,
    output logic             ack_ready,

    // Completion ports
    input  done_port_t       done_0,
    input  done_port_t       done_1,

    // Released segments
    output logic             out_valid,
    output ack_entry_t       out_entry,
    input  logic             out_ready,

    // Status
    output logic [FIFO_AW:0] pending,
    output reord_err_t       err
);

    ////////////////////
    // Flush register

    logic flush_q;

    // Held high through reset, so the block starts flushed
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flush_q <= 1'b1;
        end
        else
        begin
            flush_q <= flush;
        end
    end

    ////////////////////
    // Internal nets

    logic               head_valid;
    ack_entry_t         head_entry;
    logic               pop;
    logic [FIFO_AW:0]   fifo_count;
    logic [NUM_SEQ-1:0] done_map;
    logic               clear_valid;
    seq_id_t            clear_seq;
    logic               held;

    // FIFO occupancy plus the entry waiting at the output
    assign pending = fifo_count + (FIFO_AW+1)'(held);

    ////////////////////
    // Blocks

    ack_order_fifo #(
        .FIFO_AW    (FIFO_AW)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush_q),
        .push_valid (ack_valid),
        .push_entry (ack_entry),
        .push_ready (ack_ready),
        .head_valid (head_valid),
        .head_entry (head_entry),
        .pop        (pop),
        .count      (fifo_count)
    );

    seg_done_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush_q),
        .done_0      (done_0),
        .done_1      (done_1),
        .clear_valid (clear_valid),
        .clear_seq   (clear_seq),
        .done_map    (done_map),
        .err         (err)
    );

    seg_release u_release (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush_q),
        .head_valid  (head_valid),
        .head_entry  (head_entry),
        .pop         (pop),
        .done_map    (done_map),
        .clear_valid (clear_valid),
        .clear_seq   (clear_seq),
        .out_valid   (out_valid),
        .out_entry   (out_entry),
        .out_ready   (out_ready),
        .held        (held)
    );

endmodule

//--- hw/seg_release.sv
/* Pops the FIFO head once its id is marked done and holds it for output.
   Output register follows valid/ready and clears the done bit on load. */

`timescale 1ns/1ps

module seg_release
    import reord_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    // FIFO head
    input  logic               head_valid,
    input  ack_entry_t         head_entry,
    output logic               pop,

    // Tracker lookup and clear
    input  logic [NUM_SEQ-1:0] done_map,
    output logic               clear_valid,
    output seq_id_t            clear_seq,

    // Output, valid/ready
    output logic               out_valid,
    output ack_entry_t         out_entry,
    input  logic               out_ready,

    // Output register occupied
    output logic               held
);

    ////////////////////
    // Release decision

    logic head_done;
    logic can_load;

    // Head id already completed
    assign head_done = head_valid && done_map[head_entry.seq];

    // Register empty or being drained this edge
    assign can_load = !out_valid || out_ready;

    assign pop = head_done && can_load && !flush;

    // Clear the done bit on the same edge as the pop
    assign clear_valid = pop;
    assign clear_seq   = head_entry.seq;

    assign held = out_valid;

    ////////////////////
    // Output register

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            out_valid <= 1'b0;
        end
        else if (pop)
        begin
            out_valid <= 1'b1;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;
        end
    end

    // Payload only, stable while stalled
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            out_entry <= head_entry;
        end
    end

endmodule

//--- hw/seg_done_tracker.sv
/* Registers both completion ports and keeps one done bit per sequence id.
   Also flags duplicate completions through a registered error word. */

`timescale 1ns/1ps

module seg_done_tracker
    import reord_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    // Completion ports, no back-pressure
    input  done_port_t         done_0,
    input  done_port_t         done_1,

    // Bit clear from the release block
    input  logic               clear_valid,
    input  seq_id_t            clear_seq,

    output logic [NUM_SEQ-1:0] done_map,
    output reord_err_t         err
);

    ////////////////////
    // Input registers

    done_port_t done_0_q;
    done_port_t done_1_q;

    // Stage 1, sample both ports at edge M
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            // Drops anything caught while flushing
            done_0_q <= '0;
            done_1_q <= '0;
        end
        else
        begin
            done_0_q <= done_0;
            done_1_q <= done_1;
        end
    end

    ////////////////////
    // Duplicate detect

    logic same_id;
    logic mark_1_ok;
    reord_err_t err_d;

    // Both ports carry one id this cycle
    assign same_id = done_0_q.valid && done_1_q.valid && (done_0_q.seq == done_1_q.seq);

    // Port 1 only marks when not a copy of port 0
    assign mark_1_ok = done_1_q.valid && !same_id;

    always_comb
    begin
        err_d            = '0;
        err_d.dup_port   = same_id;
        // Hit on a bit that is still set from an earlier completion
        err_d.dup_mark_0 = done_0_q.valid && done_map[done_0_q.seq];
        err_d.dup_mark_1 = done_1_q.valid && done_map[done_1_q.seq];
    end

    ////////////////////
    // Completion bitmap

    // Stage 2, bits set at edge M+1
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            done_map <= '0;
        end
        else
        begin
            if (done_0_q.valid)
            begin
                done_map[done_0_q.seq] <= 1'b1;
            end
            if (mark_1_ok)
            begin
                done_map[done_1_q.seq] <= 1'b1;
            end
            // Release clear is last, so it wins on the same id
            if (clear_valid)
            begin
                done_map[clear_seq] <= 1'b0;
            end
        end
    end

    ////////////////////
    // Error register

    // One-cycle pulse, two edges after the port input
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            err <= '0;
        end
        else
        begin
            err <= err_d;
        end
    end

endmodule

//--- hw/ack_order_fifo.sv
/* Circular buffer holding accepted ACK entries in arrival order.
   Head is read combinationally; pop comes from the release block. */

`timescale 1ns/1ps

module ack_order_fifo
    import reord_pkg::*;
#(
    parameter int FIFO_AW = 4
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,

    // ACK side, valid/ready
    input  logic             push_valid,
    input  ack_entry_t       push_entry,
    output logic             push_ready,

    // Head towards the release block
    output logic             head_valid,
    output ack_entry_t       head_entry,
    input  logic             pop,

    // Occupancy
    output logic [FIFO_AW:0] count
);

    ////////////////////
    // Storage and pointers

    localparam int DEPTH = 1 << FIFO_AW;

    // Payload storage, no reset needed
    ack_entry_t mem [DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;

    logic full;
    logic push_fire;
    logic pop_fire;

    // Full when all DEPTH slots taken
    assign full = (count == (FIFO_AW+1)'(DEPTH));

    // Flush blocks new entries as well
    assign push_ready = !full && !flush;
    assign head_valid = (count != '0);
    assign head_entry = mem[rd_ptr];

    // Transfers on this edge
    assign push_fire = push_valid && push_ready;
    assign pop_fire  = pop && head_valid && !flush;

    ////////////////////
    // Write side

    always_ff @(posedge clk)
    begin
        if (push_fire)
        begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            wr_ptr <= '0;
        end
        else if (push_fire)
        begin
            // Wraps naturally at DEPTH
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    ////////////////////
    // Read side

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            rd_ptr <= '0;
        end
        else if (pop_fire)
        begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    ////////////////////
    // Occupancy

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            count <= '0;
        end
        else
        begin
            // Simultaneous push and pop leaves count unchanged
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/reord_pkg.sv
/* Shared widths and packed types for the in-order release block.
   Imported by every RTL module of the release path and by the testbench. */

package reord_pkg;

    ////////////////////
    // Widths

    // Sequence id width, ids wrap over NUM_SEQ values
    localparam int SEQ_W   = 4;
    localparam int NUM_SEQ = 1 << SEQ_W;

    // Segment info carried with each ACK
    localparam int INFO_W  = 40;

    ////////////////////
    // Types

    typedef logic [SEQ_W-1:0] seq_id_t;

    // One pending ACK, info in the upper bits (44 bits total)
    typedef struct packed {
        logic [INFO_W-1:0] info;
        seq_id_t           seq;
    } ack_entry_t;

    // One completion port, fire-and-forget
    typedef struct packed {
        logic    valid;
        seq_id_t seq;
    } done_port_t;

    // Sequence error flags, registered in the tracker
    typedef struct packed {
        logic dup_port;    // same id on both ports in one cycle
        logic dup_mark_0;  // port 0 hit an id already marked
        logic dup_mark_1;  // port 1 hit an id already marked
    } reord_err_t;

endpackage
